// ==== selen_pkg.sv ====
//##########################################################################
// Shared types and encodings for the execute slice
//##########################################################################

package selen_pkg;

	localparam int xlen = 32;
	localparam int nreg = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [2:0] brch_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_branch = 7'b1100011;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	localparam alu_op_t alu_add = 4'd0;
	localparam alu_op_t alu_sub = 4'd1;
	localparam alu_op_t alu_and = 4'd2;
	localparam alu_op_t alu_or = 4'd3;
	localparam alu_op_t alu_xor = 4'd4;
	localparam alu_op_t alu_slt = 4'd5;
	localparam alu_op_t alu_sltu = 4'd6;
	localparam alu_op_t alu_sll = 4'd7;
	localparam alu_op_t alu_srl = 4'd8;
	localparam alu_op_t alu_sra = 4'd9;
	localparam alu_op_t alu_pass_b = 4'd10;

	// Branch codes follow funct3, the two unused funct3 values carry none and jal
	localparam brch_t brch_beq = 3'b000;
	localparam brch_t brch_bne = 3'b001;
	localparam brch_t brch_none = 3'b010;
	localparam brch_t brch_jal = 3'b011;
	localparam brch_t brch_blt = 3'b100;
	localparam brch_t brch_bge = 3'b101;
	localparam brch_t brch_bltu = 3'b110;
	localparam brch_t brch_bgeu = 3'b111;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t rs2;
			reg_idx_t rs1;
			logic [2:0] funct3;
			reg_idx_t rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm_11_0;
			reg_idx_t rs1;
			logic [2:0] funct3;
			reg_idx_t rd;
			logic [6:0] opcode;
		} i_fmt;
		struct packed {
			logic imm_12;
			logic [5:0] imm_10_5;
			reg_idx_t rs2;
			reg_idx_t rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm_31_12;
			reg_idx_t rd;
			logic [6:0] opcode;
		} u_fmt;
		struct packed {
			logic imm_20;
			logic [9:0] imm_10_1;
			logic imm_11;
			logic [7:0] imm_19_12;
			reg_idx_t rd;
			logic [6:0] opcode;
		} j_fmt;
	} instr_u;

endpackage

// ==== instr_decode.sv ====
//##########################################################################
// Instruction decoder
//##########################################################################

`timescale 1ns/1ps

module instr_decode (
	input selen_pkg::instr_u instr,
	input selen_pkg::word_t rs1_data,
	input selen_pkg::word_t rs2_data,
	input selen_pkg::word_t pc_plus4,
	output selen_pkg::reg_idx_t rs1,
	output selen_pkg::reg_idx_t rs2,
	output selen_pkg::reg_idx_t rd,
	output selen_pkg::word_t op_a,
	output selen_pkg::word_t op_b,
	output selen_pkg::alu_op_t alu_op,
	output selen_pkg::brch_t brch,
	output selen_pkg::word_t br_base,
	output selen_pkg::word_t br_offset,
	output logic link,
	output logic we_reg
);
	import selen_pkg::*;

	word_t pc;
	word_t imm;
	logic sel_a_pc;
	logic sel_b_imm;
	logic writes_rd;

	// Subtract only exists in the register form, bit 30 selects sra in both forms
	function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		alu_op_t op;
		op = alu_add;
		case (f3)
			f3_add_sub: op = (is_reg && alt) ? alu_sub : alu_add;
			f3_sll: op = alu_sll;
			f3_slt: op = alu_slt;
			f3_sltu: op = alu_sltu;
			f3_xor: op = alu_xor;
			f3_srl_sra: op = alt ? alu_sra : alu_srl;
			f3_or: op = alu_or;
			f3_and: op = alu_and;
			default: op = alu_add;
		endcase
		return op;
	endfunction

	assign pc = pc_plus4 - word_t'(4);

	// Register indices sit at fixed positions in every format
	assign rs1 = instr.r_fmt.rs1;
	assign rs2 = instr.r_fmt.rs2;
	assign rd = instr.r_fmt.rd;

	always_comb begin
		imm = '0;
		sel_a_pc = 1'b0;
		sel_b_imm = 1'b0;
		writes_rd = 1'b0;
		link = 1'b0;
		alu_op = alu_add;
		brch = brch_none;
		case (instr.r_fmt.opcode)
			opc_op: begin
				alu_op = alu_decode(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
				writes_rd = 1'b1;
			end
			opc_op_imm: begin
				imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
				alu_op = alu_decode(instr.i_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
				sel_b_imm = 1'b1;
				writes_rd = 1'b1;
			end
			opc_lui: begin
				imm = {instr.u_fmt.imm_31_12, 12'b0};
				alu_op = alu_pass_b;
				sel_b_imm = 1'b1;
				writes_rd = 1'b1;
			end
			opc_auipc: begin
				imm = {instr.u_fmt.imm_31_12, 12'b0};
				sel_a_pc = 1'b1;
				sel_b_imm = 1'b1;
				writes_rd = 1'b1;
			end
			opc_jal: begin
				imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
					instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
				brch = brch_jal;
				link = 1'b1;
				writes_rd = 1'b1;
			end
			opc_branch: begin
				imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
					instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
				case (instr.b_fmt.funct3)
					brch_beq, brch_bne, brch_blt, brch_bge, brch_bltu, brch_bgeu:
						brch = instr.b_fmt.funct3;
					default: brch = brch_none;
				endcase
			end
			default: begin
				// Anything else passes through as a no-operation
				writes_rd = 1'b0;
			end
		endcase
	end

	assign op_a = sel_a_pc ? pc : rs1_data;
	assign op_b = sel_b_imm ? imm : rs2_data;
	assign br_base = pc;
	assign br_offset = imm;
	assign we_reg = writes_rd && (rd != '0);

endmodule

// ==== reg_file.sv ====
//##########################################################################
// Integer register file
//##########################################################################

`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input selen_pkg::reg_idx_t rs1,
	input selen_pkg::reg_idx_t rs2,
	output selen_pkg::word_t rs1_data,
	output selen_pkg::word_t rs2_data,
	input selen_pkg::reg_idx_t rd,
	input selen_pkg::word_t wdata,
	input logic we
);
	import selen_pkg::*;

	// x0 has no storage
	word_t regs [1:nreg-1];

	always_ff @(posedge clk) begin
		if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// A write in flight is visible to the reads of the same cycle
	assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

// ==== reg_exe.sv ====
//##########################################################################
// Execute stage pipeline register
//##########################################################################

`timescale 1ns/1ps

module reg_exe (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input logic nop_gen,
	input selen_pkg::word_t op_a_in,
	input selen_pkg::word_t op_b_in,
	input selen_pkg::word_t br_base_in,
	input selen_pkg::word_t br_offset_in,
	input selen_pkg::word_t pc_plus4_in,
	input selen_pkg::reg_idx_t rd_in,
	input selen_pkg::alu_op_t alu_op_in,
	input selen_pkg::brch_t brch_in,
	input logic link_in,
	input logic we_reg_in,
	output selen_pkg::word_t op_a_out,
	output selen_pkg::word_t op_b_out,
	output selen_pkg::word_t br_base_out,
	output selen_pkg::word_t br_offset_out,
	output selen_pkg::word_t pc_plus4_out,
	output selen_pkg::reg_idx_t rd_out,
	output selen_pkg::alu_op_t alu_op_out,
	output selen_pkg::brch_t brch_out,
	output logic link_out,
	output logic we_reg_out
);
	import selen_pkg::*;

	word_t op_a_q;
	word_t op_b_q;
	word_t br_base_q;
	word_t br_offset_q;
	word_t pc_plus4_q;
	reg_idx_t rd_q;
	alu_op_t alu_op_q;
	brch_t brch_q;
	logic link_q;
	logic we_reg_q;
	logic nop_q;

	// The nop request follows its input on every edge, stall or not
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			nop_q <= 1'b0;
		end else begin
			nop_q <= nop_gen;
		end
	end

	// Flush wins over stall and leaves a bubble that writes nothing
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			op_a_q <= '0;
			op_b_q <= '0;
			br_base_q <= '0;
			br_offset_q <= '0;
			pc_plus4_q <= '0;
			rd_q <= '0;
			alu_op_q <= alu_add;
			brch_q <= brch_none;
			link_q <= 1'b0;
			we_reg_q <= 1'b0;
		end else if (!stall) begin
			op_a_q <= op_a_in;
			op_b_q <= op_b_in;
			br_base_q <= br_base_in;
			br_offset_q <= br_offset_in;
			pc_plus4_q <= pc_plus4_in;
			rd_q <= rd_in;
			alu_op_q <= alu_op_in;
			brch_q <= brch_in;
			link_q <= link_in;
			we_reg_q <= we_reg_in;
		end
	end

	assign op_a_out = nop_q ? '0 : op_a_q;
	assign op_b_out = nop_q ? '0 : op_b_q;
	assign br_base_out = br_base_q;
	assign br_offset_out = br_offset_q;
	assign pc_plus4_out = pc_plus4_q;
	assign rd_out = rd_q;
	assign alu_op_out = alu_op_q;
	assign brch_out = nop_q ? brch_none : brch_q;
	assign link_out = link_q;
	assign we_reg_out = nop_q ? 1'b0 : we_reg_q;

endmodule

// ==== alu.sv ====
//##########################################################################
// Integer ALU
//##########################################################################

`timescale 1ns/1ps

module alu (
	input selen_pkg::word_t a,
	input selen_pkg::word_t b,
	input selen_pkg::alu_op_t op,
	output selen_pkg::word_t y
);
	import selen_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;

	assign shamt = b[4:0];
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or: y = a | b;
			alu_xor: y = a ^ b;
			alu_slt: y = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu: y = {{(xlen-1){1'b0}}, lt_u};
			alu_sll: y = a << shamt;
			alu_srl: y = a >> shamt;
			alu_sra: y = word_t'($signed(a) >>> shamt);
			// lui hands its immediate straight through
			alu_pass_b: y = b;
			default: y = '0;
		endcase
	end

endmodule

// ==== branch_unit.sv ====
//##########################################################################
// Branch evaluation
//##########################################################################

`timescale 1ns/1ps

module branch_unit (
	input selen_pkg::word_t rs1_val,
	input selen_pkg::word_t rs2_val,
	input selen_pkg::word_t base,
	input selen_pkg::word_t offset,
	input selen_pkg::brch_t brch,
	output logic taken,
	output selen_pkg::word_t target
);
	import selen_pkg::*;

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq = rs1_val == rs2_val;
	assign lt_s = $signed(rs1_val) < $signed(rs2_val);
	assign lt_u = rs1_val < rs2_val;

	always_comb begin
		case (brch)
			brch_beq: taken = eq;
			brch_bne: taken = !eq;
			brch_blt: taken = lt_s;
			brch_bge: taken = !lt_s;
			brch_bltu: taken = lt_u;
			brch_bgeu: taken = !lt_u;
			brch_jal: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign target = base + offset;

endmodule

// ==== exe_core.sv ====
//##########################################################################
// Decode and execute slice
//##########################################################################

`timescale 1ns/1ps

module exe_core (
	input logic clk,
	input logic rst_n,
	input selen_pkg::instr_u instr,
	input selen_pkg::word_t pc_plus4,
	input logic stall,
	input logic flush,
	input logic nop_gen,
	output selen_pkg::word_t ex_result,
	output selen_pkg::reg_idx_t ex_rd,
	output logic ex_we,
	output logic br_taken,
	output selen_pkg::word_t br_target
);
	import selen_pkg::*;

	reg_idx_t rs1, rs2, rd;
	word_t rs1_data, rs2_data;
	word_t op_a, op_b, br_base, br_offset;
	alu_op_t alu_op;
	brch_t brch;
	logic link, we_reg;

	word_t ex_op_a, ex_op_b, ex_br_base, ex_br_offset, ex_pc_plus4;
	alu_op_t ex_alu_op;
	brch_t ex_brch;
	logic ex_link;
	word_t alu_y;

	instr_decode i_decode (
		.instr(instr), .rs1_data(rs1_data), .rs2_data(rs2_data), .pc_plus4(pc_plus4),
		.rs1(rs1), .rs2(rs2), .rd(rd), .op_a(op_a), .op_b(op_b), .alu_op(alu_op),
		.brch(brch), .br_base(br_base), .br_offset(br_offset), .link(link),
		.we_reg(we_reg)
	);

	// Write port is fed back from the execute result
	reg_file i_rf (
		.clk(clk), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.rd(ex_rd), .wdata(ex_result), .we(ex_we)
	);

	reg_exe i_reg_exe (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .nop_gen(nop_gen),
		.op_a_in(op_a), .op_b_in(op_b), .br_base_in(br_base), .br_offset_in(br_offset),
		.pc_plus4_in(pc_plus4), .rd_in(rd), .alu_op_in(alu_op), .brch_in(brch),
		.link_in(link), .we_reg_in(we_reg),
		.op_a_out(ex_op_a), .op_b_out(ex_op_b), .br_base_out(ex_br_base),
		.br_offset_out(ex_br_offset), .pc_plus4_out(ex_pc_plus4), .rd_out(ex_rd),
		.alu_op_out(ex_alu_op), .brch_out(ex_brch), .link_out(ex_link),
		.we_reg_out(ex_we)
	);

	alu i_alu (
		.a(ex_op_a), .b(ex_op_b), .op(ex_alu_op), .y(alu_y)
	);

	branch_unit i_branch (
		.rs1_val(ex_op_a), .rs2_val(ex_op_b), .base(ex_br_base), .offset(ex_br_offset),
		.brch(ex_brch), .taken(br_taken), .target(br_target)
	);

	// jal writes its return address instead of the ALU value
	assign ex_result = ex_link ? ex_pc_plus4 : alu_y;

endmodule

// ==== exe_core_chk.sv ====
//##########################################################################
// Execute register assertions
//##########################################################################

`timescale 1ns/1ps

module exe_core_chk (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input logic nop_gen,
	input logic we_reg_out,
	input selen_pkg::brch_t brch_out,
	// Every held field of the register side by side
	input logic [5*selen_pkg::xlen+13:0] held
);
	import selen_pkg::*;

	bubble_after_flush: assert property (@(posedge clk) (!rst_n || flush) |=>
		(!we_reg_out && brch_out == brch_none))
		else $error("Held item still writes or branches after a flush or reset");

	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && !flush) |=> $stable(held))
		else $error("Held fields changed while the register was stalled");

	// A nop request taken at one edge masks the write and branch of whatever is held
	nop_masks_item: assert property (@(posedge clk) disable iff (!rst_n)
		nop_gen |=> (!we_reg_out && brch_out == brch_none))
		else $error("Held item still writes or branches under a registered nop request");

endmodule

bind reg_exe exe_core_chk i_chk (
	.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .nop_gen(nop_gen),
	.we_reg_out(we_reg_out), .brch_out(brch_out),
	.held({op_a_q, op_b_q, br_base_q, br_offset_q, pc_plus4_q, rd_q, alu_op_q, brch_q,
		link_q, we_reg_q})
);

// ==== tb_exe_core.sv ====
//##########################################################################
// Execute slice testbench
//##########################################################################

`timescale 1ns/1ps

module tb_exe_core;
	import selen_pkg::*;

	localparam int n_preload = nreg - 1;
	localparam int n_instr = 2000;
	localparam int run_limit = (n_instr + n_preload + 100) * 20;

	logic clk, rst_n, stall, flush, nop_gen, ex_we, br_taken;
	instr_u instr;
	word_t pc_plus4, ex_result, br_target;
	reg_idx_t ex_rd;

	// Model of the register array, the held execute item and the delayed nop request
	word_t m_regs [0:nreg-1];
	word_t h_result, h_target;
	reg_idx_t h_rd;
	logic h_we, h_taken, m_nop;

	// Fields of the instruction presented this cycle
	int cur_kind;
	reg_idx_t cur_rd, cur_rs1, cur_rs2;
	logic [2:0] cur_f3;
	logic cur_alt;
	word_t cur_imm;
	int n_writes, n_taken;

	exe_core i_dut (
		.clk(clk), .rst_n(rst_n), .instr(instr), .pc_plus4(pc_plus4), .stall(stall),
		.flush(flush), .nop_gen(nop_gen), .ex_result(ex_result), .ex_rd(ex_rd),
		.ex_we(ex_we), .br_taken(br_taken), .br_target(br_target)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(run_limit);
		$display("Timeout after %0d ns before the end of the instruction stream", run_limit);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	task automatic check_word(input string name, input word_t act, input word_t exp);
		if (act !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
			$display("Checks failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t act, input reg_idx_t exp);
		if (act !== exp) begin
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, act, exp);
			$display("Checks failed");
			$fatal(1, "index mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, act, exp);
			$display("Checks failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	function automatic word_t model_alu(input logic [2:0] f3, input logic alt, input word_t a,
			input word_t b);
		word_t y;
		case (f3)
			3'd0: y = alt ? a - b : a + b;
			3'd1: y = a << b[4:0];
			3'd2: y = word_t'($signed(a) < $signed(b));
			3'd3: y = word_t'(a < b);
			3'd4: y = a ^ b;
			// Arithmetic shift refills the vacated upper bits with the sign
			3'd5: y = (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : '0);
			3'd6: y = a | b;
			default: y = a & b;
		endcase
		return y;
	endfunction

	function automatic logic model_cond(input logic [2:0] f3, input word_t a, input word_t b);
		logic lt_s;
		logic c;
		lt_s = $signed(a) < $signed(b);
		case (f3)
			3'd0: c = a == b;
			3'd1: c = a != b;
			3'd4: c = lt_s;
			3'd5: c = !lt_s;
			3'd6: c = a < b;
			default: c = a >= b;
		endcase
		return c;
	endfunction

	task automatic clear_held();
		h_result = '0;
		h_target = '0;
		h_rd = '0;
		h_we = 1'b0;
		h_taken = 1'b0;
	endtask

	// Draws one legal instruction of the subset, or the addi that preloads a register
	task automatic make_instr(input logic preload, input reg_idx_t idx);
		logic [2:0] br_codes [6];
		logic [11:0] imm12;
		logic [19:0] imm20;
		logic [20:0] j_imm;
		logic [12:0] b_imm;
		word_t w;
		br_codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		cur_kind = $urandom_range(5);
		cur_rd = reg_idx_t'($urandom_range(31));
		cur_rs1 = ($urandom_range(3) == 0) ? h_rd : reg_idx_t'($urandom_range(31));
		cur_rs2 = reg_idx_t'($urandom_range(31));
		cur_f3 = 3'($urandom_range(7));
		cur_alt = 1'($urandom_range(1));
		imm12 = 12'($urandom);
		imm20 = 20'($urandom);
		j_imm = {20'($urandom), 1'b0};
		b_imm = {12'($urandom), 1'b0};
		if (preload) begin
			cur_kind = 1;
			cur_rd = idx;
			cur_rs1 = '0;
			cur_f3 = 3'd0;
		end
		// Only sub and sra use the alternate encoding, and sub has no immediate form
		if (cur_f3 != 3'd5 && (cur_kind == 1 || cur_f3 != 3'd0)) begin
			cur_alt = 1'b0;
		end
		if (cur_kind == 1 && (cur_f3 == 3'd1 || cur_f3 == 3'd5)) begin
			imm12 = {1'b0, cur_alt, 5'b0, imm12[4:0]};
		end
		cur_imm = {{20{imm12[11]}}, imm12};
		case (cur_kind)
			0: w = {1'b0, cur_alt, 5'b0, cur_rs2, cur_rs1, cur_f3, cur_rd, opc_op};
			1: w = {imm12, cur_rs1, cur_f3, cur_rd, opc_op_imm};
			2, 3: begin
				cur_imm = {imm20, 12'b0};
				w = {imm20, cur_rd, (cur_kind == 2) ? opc_lui : opc_auipc};
			end
			4: begin
				cur_imm = {{11{j_imm[20]}}, j_imm};
				w = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], cur_rd, opc_jal};
			end
			default: begin
				cur_f3 = br_codes[$urandom_range(5)];
				cur_rd = {b_imm[4:1], b_imm[11]};
				cur_imm = {{19{b_imm[12]}}, b_imm};
				w = {b_imm[12], b_imm[10:5], cur_rs2, cur_rs1, cur_f3, b_imm[4:1], b_imm[11],
					opc_branch};
			end
		endcase
		instr = instr_u'(w);
		pc_plus4 = {30'($urandom), 2'b00};
	endtask

	// One rising edge: the held item writes back, then the new item is latched
	task automatic model_edge();
		word_t a;
		word_t b;
		word_t pc;
		if (h_we && !m_nop) begin
			m_regs[h_rd] = h_result;
			n_writes++;
		end
		if (h_taken && !m_nop) begin
			n_taken++;
		end
		// Operands already see that write
		a = m_regs[cur_rs1];
		b = m_regs[cur_rs2];
		pc = pc_plus4 - 32'd4;
		if (flush) begin
			clear_held();
		end else if (!stall) begin
			h_rd = cur_rd;
			h_we = (cur_kind != 5) && (cur_rd != '0);
			h_taken = (cur_kind == 4);
			h_target = pc + cur_imm;
			case (cur_kind)
				0: h_result = model_alu(cur_f3, cur_alt, a, b);
				1: h_result = model_alu(cur_f3, cur_alt, a, cur_imm);
				2: h_result = cur_imm;
				3: h_result = pc + cur_imm;
				4: h_result = pc_plus4;
				default: h_taken = model_cond(cur_f3, a, b);
			endcase
		end
		m_nop = nop_gen;
	endtask

	task automatic check_outputs();
		check_bit("ex_we", ex_we, h_we && !m_nop);
		check_bit("br_taken", br_taken, h_taken && !m_nop);
		check_idx("ex_rd", ex_rd, h_rd);
		if (h_we && !m_nop) begin
			check_word("ex_result", ex_result, h_result);
		end
		if (h_taken && !m_nop) begin
			check_word("br_target", br_target, h_target);
		end
	endtask

	initial begin
		void'($urandom(62));
		rst_n = 1'b0;
		instr = '0;
		pc_plus4 = '0;
		stall = 1'b0;
		flush = 1'b0;
		nop_gen = 1'b0;
		n_writes = 0;
		n_taken = 0;
		m_nop = 1'b0;
		clear_held();
		for (int i = 0; i < nreg; i++) begin
			m_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// The first cycles preload x1 to x31, the rest are random
		for (int i = 0; i < n_preload + n_instr; i++) begin
			check_outputs();
			make_instr(i < n_preload, reg_idx_t'(i + 1));
			stall = (i >= n_preload) && ($urandom_range(99) < 15);
			flush = (i >= n_preload) && ($urandom_range(99) < 5);
			nop_gen = (i >= n_preload) && ($urandom_range(99) < 5);
			@(posedge clk);
			model_edge();
			@(negedge clk);
		end
		check_outputs();
		if (n_writes > n_preload && n_taken > 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Too few register writes or taken branches were seen in the run");
			$display("Checks failed");
			$fatal(1, "stimulus did not reach the expected activity");
		end
	end

endmodule

// ==== list.f ====
selen_pkg.sv
instr_decode.sv
reg_file.sv
reg_exe.sv
alu.sv
branch_unit.sv
exe_core.sv
exe_core_chk.sv
tb_exe_core.sv
